/* Bender.yml */
package:
  name: ps_reg_bridge

sources:
  - files:
      - common/reg_map_pkg.sv
      - common/ps_req_if.sv
      - common/ps_rsp_if.sv
      - hdl/ps_req_capture.sv
      - reg_map/reg_map.sv
      - hdl/ps_resp_gen.sv
      - hdl/ps_reg_bridge.sv
  - target: test
    files:
      - testbench/bridge_checker.sv
      - testbench/tb_ps_reg_bridge.sv

/* common/ps_req_if.sv */
`default_nettype none

// Pending PS requests, capture stage to register map
interface ps_req_if;
	import reg_map_pkg::*;

	logic wr_pending;
	idx_t wr_index;
	word_t wr_data;
	logic rd_pending;
	idx_t rd_index;
	logic wr_done; // Pulse in accept cycle
	logic rd_done;

	modport capture (
		output wr_pending, wr_index, wr_data, rd_pending, rd_index,
		input wr_done, rd_done
	);

	modport map (
		input wr_pending, wr_index, wr_data, rd_pending, rd_index,
		output wr_done, rd_done
	);

endinterface

`default_nettype wire

/* common/ps_rsp_if.sv */
`default_nettype none

// Responses from the register map and holder status back to it
interface ps_rsp_if;
	import reg_map_pkg::*;

	logic wresp_load;
	resp_t wresp;
	logic rdata_load;
	word_t rdata;
	logic wslot_free; // Write response holder empty
	logic rslot_free;

	modport map (
		output wresp_load, wresp, rdata_load, rdata,
		input wslot_free, rslot_free
	);

	modport resp (
		input wresp_load, wresp, rdata_load, rdata,
		output wslot_free, rslot_free
	);

endinterface

`default_nettype wire

/* common/reg_map_pkg.sv */
`default_nettype none

package reg_map_pkg;

	localparam int MEM_SIZE = 16;

	typedef logic [3:0] idx_t;
	typedef logic [31:0] word_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// Register indices
	localparam idx_t VERSION_ID = 4'd0;
	localparam idx_t MEM_SIZE_ID = 4'd1;
	localparam idx_t MAX_BURST_ID = 4'd2;
	localparam idx_t BURST_SIZE_ID = 4'd3;
	localparam idx_t SCALE_ID = 4'd4;
	localparam idx_t POLL_BASE_ID = 4'd5;
	localparam idx_t POLL_END_ID = 4'd8; // One past the last poll register
	localparam idx_t TEST_BASE_ID = 4'd12;

	function automatic logic is_readonly(idx_t idx);
		return idx <= MAX_BURST_ID;
	endfunction

	function automatic logic is_poll(idx_t idx);
		return idx >= POLL_BASE_ID && idx < POLL_END_ID;
	endfunction

	function automatic logic is_test(idx_t idx);
		return idx >= TEST_BASE_ID;
	endfunction

	// Value of a register right after reset
	function automatic word_t reset_value(idx_t idx, word_t fw_version, word_t max_burst);
		case (idx)
			VERSION_ID: return fw_version;
			MEM_SIZE_ID: return word_t'(MEM_SIZE);
			MAX_BURST_ID: return max_burst;
			BURST_SIZE_ID, SCALE_ID: return '0;
			default: return '1;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hdl/ps_reg_bridge.sv */
`default_nettype none

module ps_reg_bridge #(
	parameter reg_map_pkg::word_t FIRMWARE_VERSION = 32'h0001_0203,
	parameter int MAX_BURST = 64,
	parameter int MAX_SCALE = 8
) (
	input logic clk,
	input logic rst,
	// PS side
	input logic ps_waddr_valid,
	input reg_map_pkg::idx_t ps_waddr,
	input logic ps_wdata_valid,
	input reg_map_pkg::word_t ps_wdata,
	input logic ps_raddr_valid,
	input reg_map_pkg::idx_t ps_raddr,
	input logic ps_rsp_rdy,
	output logic ps_wr_busy,
	output logic ps_rd_busy,
	output logic ps_wresp_valid,
	output reg_map_pkg::resp_t ps_wresp,
	output logic ps_rdata_valid,
	output reg_map_pkg::word_t ps_rdata,
	// RTL side
	input logic [reg_map_pkg::MEM_SIZE-1:0] rtl_write_reqs,
	input reg_map_pkg::word_t [reg_map_pkg::MEM_SIZE-1:0] rtl_wd_in,
	input logic [reg_map_pkg::MEM_SIZE-1:0] rtl_read_reqs,
	input logic [reg_map_pkg::MEM_SIZE-1:0] rtl_rdy,
	input logic clr_rd_out,
	output reg_map_pkg::word_t [reg_map_pkg::MEM_SIZE-1:0] rtl_rd_out,
	output logic [reg_map_pkg::MEM_SIZE-1:0] fresh_bits
);

	ps_req_if req_bus ();
	ps_rsp_if rsp_bus ();

	ps_req_capture capture0 (
		.clk(clk),
		.rst(rst),
		.ps_waddr_valid(ps_waddr_valid),
		.ps_wdata_valid(ps_wdata_valid),
		.ps_raddr_valid(ps_raddr_valid),
		.ps_waddr(ps_waddr),
		.ps_raddr(ps_raddr),
		.ps_wdata(ps_wdata),
		.req(req_bus.capture),
		.wr_busy(ps_wr_busy),
		.rd_busy(ps_rd_busy)
	);

	reg_map #(
		.FIRMWARE_VERSION(FIRMWARE_VERSION),
		.MAX_BURST(MAX_BURST),
		.MAX_SCALE(MAX_SCALE)
	) map0 (
		.clk(clk),
		.rst(rst),
		.req(req_bus.map),
		.rsp(rsp_bus.map),
		.rtl_write_reqs(rtl_write_reqs),
		.rtl_read_reqs(rtl_read_reqs),
		.rtl_rdy(rtl_rdy),
		.rtl_wd_in(rtl_wd_in),
		.clr_rd_out(clr_rd_out),
		.rtl_rd_out(rtl_rd_out),
		.fresh_bits(fresh_bits)
	);

	ps_resp_gen resp0 (
		.clk(clk),
		.rst(rst),
		.rsp(rsp_bus.resp),
		.ps_rsp_rdy(ps_rsp_rdy),
		.ps_wresp_valid(ps_wresp_valid),
		.ps_rdata_valid(ps_rdata_valid),
		.ps_wresp(ps_wresp),
		.ps_rdata(ps_rdata)
	);

endmodule

`default_nettype wire

/* hdl/ps_req_capture.sv */
`default_nettype none

module ps_req_capture (
	input logic clk,
	input logic rst,
	input logic ps_waddr_valid,
	input logic ps_wdata_valid,
	input logic ps_raddr_valid,
	input reg_map_pkg::idx_t ps_waddr,
	input reg_map_pkg::idx_t ps_raddr,
	input reg_map_pkg::word_t ps_wdata,
	ps_req_if.capture req,
	output logic wr_busy,
	output logic rd_busy
);

	logic have_waddr;
	logic have_wdata;
	logic rd_held;

	// Address and data may arrive in either order
	always_ff @(posedge clk) begin
		if (rst) begin
			have_waddr <= 1'b0;
			have_wdata <= 1'b0;
			rd_held <= 1'b0;
		end else begin
			if (req.wr_done) begin
				have_waddr <= 1'b0;
				have_wdata <= 1'b0;
			end
			if (ps_waddr_valid)
				have_waddr <= 1'b1;
			if (ps_wdata_valid)
				have_wdata <= 1'b1;

			if (req.rd_done)
				rd_held <= 1'b0;
			if (ps_raddr_valid)
				rd_held <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ps_waddr_valid)
			req.wr_index <= ps_waddr;
		if (ps_wdata_valid)
			req.wr_data <= ps_wdata;
		if (ps_raddr_valid)
			req.rd_index <= ps_raddr;
	end

	assign req.wr_pending = have_waddr && have_wdata;
	assign req.rd_pending = rd_held;

	assign wr_busy = req.wr_pending; // Held until the edge after wr_done
	assign rd_busy = req.rd_pending;

endmodule

`default_nettype wire

/* hdl/ps_resp_gen.sv */
`default_nettype none

module ps_resp_gen (
	input logic clk,
	input logic rst,
	ps_rsp_if.resp rsp,
	input logic ps_rsp_rdy,
	output logic ps_wresp_valid,
	output logic ps_rdata_valid,
	output reg_map_pkg::resp_t ps_wresp,
	output reg_map_pkg::word_t ps_rdata
);

	always_ff @(posedge clk) begin
		if (rst) begin
			ps_wresp_valid <= 1'b0;
			ps_rdata_valid <= 1'b0;
		end else begin
			if (ps_rsp_rdy) begin // Taken by the PS side
				ps_wresp_valid <= 1'b0;
				ps_rdata_valid <= 1'b0;
			end
			// Loads only arrive into an empty holder
			if (rsp.wresp_load)
				ps_wresp_valid <= 1'b1;
			if (rsp.rdata_load)
				ps_rdata_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp.wresp_load)
			ps_wresp <= rsp.wresp;
		if (rsp.rdata_load)
			ps_rdata <= rsp.rdata;
	end

	assign rsp.wslot_free = !ps_wresp_valid;
	assign rsp.rslot_free = !ps_rdata_valid;

endmodule

`default_nettype wire

/* ps_reg_bridge.f */
common/reg_map_pkg.sv
common/ps_req_if.sv
common/ps_rsp_if.sv
hdl/ps_req_capture.sv
reg_map/reg_map.sv
hdl/ps_resp_gen.sv
hdl/ps_reg_bridge.sv
testbench/bridge_checker.sv
testbench/tb_ps_reg_bridge.sv

/* reg_map/reg_map.sv */
`default_nettype none

module reg_map #(
	parameter reg_map_pkg::word_t FIRMWARE_VERSION = 32'h0001_0203,
	parameter int MAX_BURST = 64,
	parameter int MAX_SCALE = 8
) (
	input logic clk,
	input logic rst,
	ps_req_if.map req,
	ps_rsp_if.map rsp,
	input logic [reg_map_pkg::MEM_SIZE-1:0] rtl_write_reqs,
	input logic [reg_map_pkg::MEM_SIZE-1:0] rtl_read_reqs,
	input logic [reg_map_pkg::MEM_SIZE-1:0] rtl_rdy,
	input reg_map_pkg::word_t [reg_map_pkg::MEM_SIZE-1:0] rtl_wd_in,
	input logic clr_rd_out,
	output reg_map_pkg::word_t [reg_map_pkg::MEM_SIZE-1:0] rtl_rd_out,
	output logic [reg_map_pkg::MEM_SIZE-1:0] fresh_bits
);

	import reg_map_pkg::*;

	localparam word_t MAX_BURST_W = word_t'(MAX_BURST);
	localparam word_t MAX_SCALE_W = word_t'(MAX_SCALE);
	localparam idx_t LAST_ID = idx_t'(MEM_SIZE - 1);

	word_t [MEM_SIZE-1:0] mem;
	logic [MEM_SIZE-1:0] rtl_wr_eff;
	logic [MEM_SIZE-1:0] rtl_rd_eff;
	logic ps_wr_accept;
	logic ps_rd_accept;
	idx_t wr_next;
	word_t wr_word;

	// Filter raw RTL requests by register class
	always_comb begin
		for (int i = 0; i < MEM_SIZE; i++) begin
			if (is_poll(idx_t'(i))) begin
				rtl_rd_eff[i] = fresh_bits[i] && rtl_rdy[i];
				rtl_wr_eff[i] = 1'b0;
			end else if (is_readonly(idx_t'(i))) begin
				rtl_rd_eff[i] = rtl_read_reqs[i];
				rtl_wr_eff[i] = 1'b0;
			end else begin
				rtl_rd_eff[i] = rtl_read_reqs[i];
				rtl_wr_eff[i] = rtl_write_reqs[i];
			end
		end
	end

	// RTL side has priority on the same index
	assign ps_wr_accept = req.wr_pending && rsp.wslot_free
		&& !rtl_wr_eff[req.wr_index] && !rtl_rd_eff[req.wr_index];
	assign ps_rd_accept = req.rd_pending && rsp.rslot_free
		&& !rtl_wr_eff[req.rd_index] && !rtl_rd_eff[req.rd_index];

	assign req.wr_done = ps_wr_accept;
	assign req.rd_done = ps_rd_accept;

	assign rsp.wresp_load = ps_wr_accept;
	assign rsp.wresp = is_readonly(req.wr_index) ? RESP_SLVERR : RESP_OKAY;
	assign rsp.rdata_load = ps_rd_accept;
	assign rsp.rdata = mem[req.rd_index];

	assign wr_next = req.wr_index + 4'd1; // Test pair neighbor

	// Word stored at the written index
	always_comb begin
		case (req.wr_index)
			BURST_SIZE_ID: wr_word = (req.wr_data > MAX_BURST_W) ? MAX_BURST_W : req.wr_data;
			SCALE_ID: wr_word = (req.wr_data > MAX_SCALE_W) ? MAX_SCALE_W : req.wr_data;
			default: wr_word = is_test(req.wr_index) ? req.wr_data - 32'd10 : req.wr_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fresh_bits <= '0;
			rtl_rd_out <= '0;
			for (int i = 0; i < MEM_SIZE; i++)
				mem[i] <= reset_value(idx_t'(i), FIRMWARE_VERSION, MAX_BURST_W);
		end else begin
			for (int i = 0; i < MEM_SIZE; i++) begin
				if (rtl_wr_eff[i]) begin
					mem[i] <= rtl_wd_in[i];
					fresh_bits[i] <= 1'b1;
				end
				if (clr_rd_out) begin
					rtl_rd_out[i] <= '0;
				end else if (rtl_rd_eff[i]) begin
					rtl_rd_out[i] <= mem[i];
					if (!rtl_wr_eff[i])
						fresh_bits[i] <= 1'b0;
				end
			end

			// PS updates come last so they win on a shared index
			if (ps_wr_accept && !is_readonly(req.wr_index)) begin
				mem[req.wr_index] <= wr_word;
				fresh_bits[req.wr_index] <= 1'b1;
				if (is_test(req.wr_index) && req.wr_index != LAST_ID) begin
					mem[wr_next] <= req.wr_data + 32'd10;
					fresh_bits[wr_next] <= 1'b1;
				end
			end

			if (ps_rd_accept)
				fresh_bits[req.rd_index] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* testbench/bridge_checker.sv */
`default_nettype none

module bridge_checker #(
	parameter reg_map_pkg::word_t FIRMWARE_VERSION = 32'h0001_0203,
	parameter int MAX_BURST = 64,
	parameter int MAX_SCALE = 8
) (
	input logic clk,
	input logic rst,
	input logic ps_waddr_valid,
	input reg_map_pkg::idx_t ps_waddr,
	input logic ps_wdata_valid,
	input reg_map_pkg::word_t ps_wdata,
	input logic ps_raddr_valid,
	input reg_map_pkg::idx_t ps_raddr,
	input logic ps_rsp_rdy,
	input logic ps_wr_busy,
	input logic ps_rd_busy,
	input logic ps_wresp_valid,
	input reg_map_pkg::resp_t ps_wresp,
	input logic ps_rdata_valid,
	input reg_map_pkg::word_t ps_rdata,
	input logic [15:0] rtl_write_reqs,
	input reg_map_pkg::word_t [15:0] rtl_wd_in,
	input logic [15:0] rtl_read_reqs,
	input logic [15:0] rtl_rdy,
	input logic clr_rd_out,
	input reg_map_pkg::word_t [15:0] rtl_rd_out,
	input logic [15:0] fresh_bits,
	output int errors,
	output int checks
);
	timeunit 1ns;
	timeprecision 1ps;

	import reg_map_pkg::*;

	word_t mem [16];
	word_t rd_out [16];
	logic [15:0] fresh;
	logic w_addr_held;
	logic w_data_held;
	logic r_held;
	idx_t w_idx;
	idx_t r_idx;
	word_t w_data;
	logic wvalid; // Model of the response holders
	logic rvalid;
	resp_t wresp_exp;
	word_t rdata_exp;

	function automatic logic ro_index(int i);
		return i <= 2;
	endfunction

	function automatic logic poll_index(int i);
		return i >= 5 && i <= 7;
	endfunction

	function automatic word_t initial_word(int i);
		case (i)
			0: return FIRMWARE_VERSION;
			1: return 32'd16;
			2: return word_t'(MAX_BURST);
			3, 4: return '0;
			default: return '1;
		endcase
	endfunction

	// Word a PS write leaves at its own index
	function automatic word_t stored_word(int i, word_t d);
		if (i == 3)
			return (d > word_t'(MAX_BURST)) ? word_t'(MAX_BURST) : d;
		if (i == 4)
			return (d > word_t'(MAX_SCALE)) ? word_t'(MAX_SCALE) : d;
		if (i >= 12)
			return d - 32'd10;
		return d;
	endfunction

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
	end

	always @(posedge clk) begin : model_step
		logic [15:0] wr_eff;
		logic [15:0] rd_eff;
		logic wr_acc;
		logic rd_acc;
		word_t old_mem [16];
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				mem[i] = initial_word(i);
				rd_out[i] = '0;
			end
			fresh = '0;
			w_addr_held = 1'b0;
			w_data_held = 1'b0;
			r_held = 1'b0;
			wvalid = 1'b0;
			rvalid = 1'b0;
		end else begin
			old_mem = mem;
			for (int i = 0; i < 16; i++) begin
				rd_eff[i] = poll_index(i) ? (fresh[i] && rtl_rdy[i]) : rtl_read_reqs[i];
				wr_eff[i] = rtl_write_reqs[i] && !poll_index(i) && !ro_index(i);
			end
			wr_acc = w_addr_held && w_data_held && !wvalid
				&& !wr_eff[w_idx] && !rd_eff[w_idx];
			rd_acc = r_held && !rvalid && !wr_eff[r_idx] && !rd_eff[r_idx];

			for (int i = 0; i < 16; i++) begin
				if (wr_eff[i]) begin
					mem[i] = rtl_wd_in[i];
					fresh[i] = 1'b1;
				end
				if (clr_rd_out) begin
					rd_out[i] = '0;
				end else if (rd_eff[i]) begin
					rd_out[i] = old_mem[i];
					if (!wr_eff[i])
						fresh[i] = 1'b0;
				end
			end

			// PS write lands after the RTL side
			if (wr_acc && !ro_index(w_idx)) begin
				mem[w_idx] = stored_word(w_idx, w_data);
				fresh[w_idx] = 1'b1;
				if (w_idx >= 12 && w_idx != 15) begin
					mem[w_idx + 1] = w_data + 32'd10;
					fresh[w_idx + 1] = 1'b1;
				end
			end
			if (rd_acc)
				fresh[r_idx] = 1'b0;

			if (ps_rsp_rdy) begin
				wvalid = 1'b0;
				rvalid = 1'b0;
			end
			if (wr_acc) begin
				wvalid = 1'b1;
				wresp_exp = ro_index(w_idx) ? RESP_SLVERR : RESP_OKAY;
				w_addr_held = 1'b0;
				w_data_held = 1'b0;
			end
			if (rd_acc) begin
				rvalid = 1'b1;
				rdata_exp = old_mem[r_idx];
				r_held = 1'b0;
			end

			if (ps_waddr_valid) begin
				w_addr_held = 1'b1;
				w_idx = ps_waddr;
			end
			if (ps_wdata_valid) begin
				w_data_held = 1'b1;
				w_data = ps_wdata;
			end
			if (ps_raddr_valid) begin
				r_held = 1'b1;
				r_idx = ps_raddr;
			end
		end
	end

	// Outputs are settled mid cycle
	always @(negedge clk) begin
		if (!rst) begin
			compare_value("ps_wr_busy", ps_wr_busy, w_addr_held && w_data_held);
			compare_value("ps_rd_busy", ps_rd_busy, r_held);
			compare_value("ps_wresp_valid", ps_wresp_valid, wvalid);
			compare_value("ps_rdata_valid", ps_rdata_valid, rvalid);
			if (wvalid)
				compare_value("ps_wresp", ps_wresp, wresp_exp);
			if (rvalid)
				compare_value("ps_rdata", ps_rdata, rdata_exp);
			compare_value("fresh_bits", fresh_bits, fresh);
			for (int i = 0; i < 16; i++)
				compare_value($sformatf("rtl_rd_out[%0d]", i), rtl_rd_out[i], rd_out[i]);
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_ps_reg_bridge.sv */
`default_nettype none

module tb_ps_reg_bridge;
	timeunit 1ns;
	timeprecision 1ps;

	import reg_map_pkg::*;

	localparam word_t FIRMWARE_VERSION = 32'h0001_0203;
	localparam int MAX_BURST = 64;
	localparam int MAX_SCALE = 8;
	localparam int NUM_RAND = 40;
	localparam int NUM_RTL = 30;
	localparam int NUM_TXN = 16 + 2 * NUM_RAND + NUM_RTL + 16;

	logic clk;
	logic rst;
	logic ps_waddr_valid;
	idx_t ps_waddr;
	logic ps_wdata_valid;
	word_t ps_wdata;
	logic ps_raddr_valid;
	idx_t ps_raddr;
	logic ps_rsp_rdy;
	logic ps_wr_busy;
	logic ps_rd_busy;
	logic ps_wresp_valid;
	resp_t ps_wresp;
	logic ps_rdata_valid;
	word_t ps_rdata;
	logic [15:0] rtl_write_reqs;
	word_t [15:0] rtl_wd_in;
	logic [15:0] rtl_read_reqs;
	logic [15:0] rtl_rdy;
	logic clr_rd_out;
	word_t [15:0] rtl_rd_out;
	logic [15:0] fresh_bits;
	int errors;
	int checks;
	int rdy_mode; // 0 random, 1 low, 2 high
	logic rtl_random;

	ps_reg_bridge #(
		.FIRMWARE_VERSION(FIRMWARE_VERSION),
		.MAX_BURST(MAX_BURST),
		.MAX_SCALE(MAX_SCALE)
	) dut0 (.*);

	bridge_checker #(
		.FIRMWARE_VERSION(FIRMWARE_VERSION),
		.MAX_BURST(MAX_BURST),
		.MAX_SCALE(MAX_SCALE)
	) checker0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic word_t pick_data();
		return $urandom_range(1) ? word_t'($urandom_range(100)) : word_t'($urandom());
	endfunction

	task automatic rtl_quiet();
		rtl_write_reqs = '0;
		rtl_wd_in = '0;
		rtl_read_reqs = '0;
		rtl_rdy = '0;
		clr_rd_out = 1'b0;
	endtask

	task automatic drive_rsp_rdy();
		int mode;
		forever begin
			@(posedge clk);
			mode = rdy_mode;
			#2;
			case (mode)
				0: ps_rsp_rdy = 1'($urandom_range(1));
				1: ps_rsp_rdy = 1'b0;
				default: ps_rsp_rdy = 1'b1;
			endcase
		end
	endtask

	task automatic drive_rtl();
		logic active;
		forever begin
			@(posedge clk);
			active = rtl_random;
			#2;
			if (active) begin
				rtl_write_reqs = 16'($urandom() & $urandom()); // About one in four
				rtl_read_reqs = 16'($urandom() & $urandom());
				rtl_rdy = 16'($urandom());
				for (int i = 0; i < MEM_SIZE; i++)
					rtl_wd_in[i] = $urandom();
				clr_rd_out = ($urandom_range(7) == 0);
			end
		end
	endtask

	// Address and data strobes in a random order
	task automatic ps_write(input idx_t idx, input word_t data);
		int order;
		order = $urandom_range(2);
		while (ps_wr_busy)
			next_cycle();
		if (order != 2) begin
			ps_waddr_valid = 1'b1;
			ps_waddr = idx;
		end
		if (order != 1) begin
			ps_wdata_valid = 1'b1;
			ps_wdata = data;
		end
		next_cycle();
		ps_waddr_valid = 1'b0;
		ps_wdata_valid = 1'b0;
		if (order != 0) begin
			repeat ($urandom_range(2)) next_cycle();
			if (order == 1) begin
				ps_wdata_valid = 1'b1;
				ps_wdata = data;
			end else begin
				ps_waddr_valid = 1'b1;
				ps_waddr = idx;
			end
			next_cycle();
			ps_waddr_valid = 1'b0;
			ps_wdata_valid = 1'b0;
		end
	endtask

	task automatic ps_read(input idx_t idx);
		while (ps_rd_busy)
			next_cycle();
		ps_raddr_valid = 1'b1;
		ps_raddr = idx;
		next_cycle();
		ps_raddr_valid = 1'b0;
	endtask

	task automatic drain();
		while (ps_wr_busy || ps_rd_busy || ps_wresp_valid || ps_rdata_valid)
			next_cycle();
	endtask

	task automatic end_test(input string name);
		$display("test %s done, %0d errors so far", name, errors);
	endtask

	initial begin
		void'($urandom(32'h4283_77d1));
		ps_waddr_valid = 1'b0;
		ps_waddr = '0;
		ps_wdata_valid = 1'b0;
		ps_wdata = '0;
		ps_raddr_valid = 1'b0;
		ps_raddr = '0;
		ps_rsp_rdy = 1'b1;
		rtl_quiet();
		rdy_mode = 2;
		rtl_random = 1'b0;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		fork
			drive_rsp_rdy();
			drive_rtl();
		join_none

		for (int i = 0; i < MEM_SIZE; i++)
			ps_read(idx_t'(i));
		drain();
		end_test("reset_values");

		rdy_mode = 0;
		ps_write(4'd15, pick_data()); // Pair rule stops at the last index
		ps_write(4'd1, 32'h5a5a_5a5a);
		fork
			repeat (NUM_RAND) ps_write(idx_t'($urandom_range(15)), pick_data());
			repeat (NUM_RAND) ps_read(idx_t'($urandom_range(15)));
		join
		drain();
		end_test("random_ps_access");

		rdy_mode = 2;
		ps_write(4'd9, pick_data());
		drain();
		ps_read(4'd9);
		ps_write(4'd10, pick_data());
		ps_write(4'd6, pick_data());
		drain();
		rtl_read_reqs[10] = 1'b1;
		rtl_rdy[6] = 1'b1; // Poll read of a fresh register
		next_cycle();
		rtl_quiet();
		drain();
		end_test("fresh_bits");

		rtl_random = 1'b1;
		repeat (NUM_RTL) ps_write(idx_t'($urandom_range(15)), pick_data());
		rtl_random = 1'b0;
		next_cycle();
		rtl_quiet();
		drain();
		end_test("rtl_access");

		rdy_mode = 1;
		rtl_write_reqs[9] = 1'b1;
		rtl_wd_in[9] = 32'h1234_5678;
		rtl_read_reqs[11] = 1'b1;
		fork
			ps_write(4'd9, pick_data());
			ps_read(4'd11);
		join
		repeat (4) next_cycle();
		rtl_quiet();
		fork
			ps_write(4'd10, pick_data());
			ps_read(4'd8);
		join
		repeat (6) next_cycle(); // Second pair waits behind full holders
		rdy_mode = 2;
		drain();
		end_test("conflict_backpressure");

		repeat (2) next_cycle();
		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(NUM_TXN * 40 * 20);
		$display("timeout: tests still running after %0d cycles", NUM_TXN * 40);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
